/* verilog/sprite_pkg.sv */
`default_nettype none

package sprite_pkg;

    localparam int COORD_W    = 10;
    localparam int COLOR_W    = 8;
    localparam int ROM_ADDR_W = 8;

    typedef logic [COORD_W-1:0]    coord_t;     // Screen coordinate
    typedef logic [COLOR_W-1:0]    color_t;     // RGB332
    typedef logic [ROM_ADDR_W-1:0] rom_addr_t;  // Texel index within one frame

    // Encoding doubles as the ROM frame index
    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        FORWARD      = 3'd1,
        BACKWARD     = 3'd2,
        ATTACK_START = 3'd3,
        ATTACK_PULL  = 3'd5,
        ATTACK_END   = 3'd4
    } pose_t;

    // Horizontal timing in pixels
    localparam coord_t H_ACTIVE     = 10'd64;
    localparam coord_t H_TOTAL      = 10'd80;
    localparam coord_t H_SYNC_START = 10'd68;
    localparam coord_t H_SYNC_END   = 10'd76;

    // Vertical timing in lines
    localparam coord_t V_ACTIVE     = 10'd48;
    localparam coord_t V_TOTAL      = 10'd52;
    localparam coord_t V_SYNC_START = 10'd49;
    localparam coord_t V_SYNC_END   = 10'd51;

    // Sprite geometry
    localparam coord_t SPRITE_W    = 10'd16;
    localparam coord_t SPRITE_H    = 10'd16;
    localparam int     FRAME_COUNT = 6;
    localparam int     FRAME_WORDS = 256;      // SPRITE_W * SPRITE_H

    localparam color_t TRANSPARENT_COLOR = 8'hE3;  // Colour key
    localparam color_t BACKGROUND_COLOR  = 8'h00;

endpackage

`default_nettype wire

/* verilog/raster_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface raster_if;

    sprite_pkg::coord_t x;       // Pixel column
    sprite_pkg::coord_t y;       // Line number
    logic               active;  // Visible area
    logic               hsync;
    logic               vsync;

    modport scan (
        output x, y, active, hsync, vsync
    );

    modport view (
        input x, y, active, hsync, vsync
    );

endinterface

`default_nettype wire

/* verilog/raster_scan.sv */
`timescale 1ns/1ns
`default_nettype none

module raster_scan (
    input  wire logic   clk,
    input  wire logic   rst,
    raster_if.scan      raster,
    output logic        frame_start
);

    sprite_pkg::coord_t x_next;
    sprite_pkg::coord_t y_next;
    logic               line_end;

    assign line_end = (raster.x == sprite_pkg::H_TOTAL - 10'd1);

    always_comb begin
        x_next = line_end ? '0 : raster.x + 10'd1;
        y_next = raster.y;
        if (line_end) begin
            if (raster.y == sprite_pkg::V_TOTAL - 10'd1) begin
                y_next = '0;  // Wrap to top of screen
            end else begin
                y_next = raster.y + 10'd1;
            end
        end
    end

    // Flags are computed from the next position so they line up with x and y
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raster.x      <= '0;
            raster.y      <= '0;
            raster.active <= 1'b1;  // Origin is a visible pixel
            raster.hsync  <= 1'b0;
            raster.vsync  <= 1'b0;
            frame_start   <= 1'b1;  // First cycle is the screen origin
        end else begin
            raster.x      <= x_next;
            raster.y      <= y_next;
            raster.active <= (x_next < sprite_pkg::H_ACTIVE) &&
                             (y_next < sprite_pkg::V_ACTIVE);
            raster.hsync  <= (x_next >= sprite_pkg::H_SYNC_START) &&
                             (x_next < sprite_pkg::H_SYNC_END);
            raster.vsync  <= (y_next >= sprite_pkg::V_SYNC_START) &&
                             (y_next < sprite_pkg::V_SYNC_END);
            frame_start   <= (x_next == '0) && (y_next == '0);
        end
    end

endmodule

`default_nettype wire

/* verilog/player_pose.sv */
`timescale 1ns/1ns
`default_nettype none

module player_pose (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                frame_start,
    input  wire logic                move_fwd,
    input  wire logic                move_back,
    input  wire logic                attack,
    input  wire sprite_pkg::coord_t  pos_x,
    input  wire sprite_pkg::coord_t  pos_y,
    output sprite_pkg::pose_t        pose,
    output sprite_pkg::coord_t       sprite_x,
    output sprite_pkg::coord_t       sprite_y
);

    sprite_pkg::pose_t pose_next;

    // Attack runs start, pull, end regardless of the controls
    always_comb begin
        case (pose)
            sprite_pkg::ATTACK_START: begin
                pose_next = sprite_pkg::ATTACK_PULL;
            end
            sprite_pkg::ATTACK_PULL: begin
                pose_next = sprite_pkg::ATTACK_END;
            end
            default: begin
                if (attack) begin
                    pose_next = sprite_pkg::ATTACK_START;
                end else if (move_fwd) begin
                    pose_next = sprite_pkg::FORWARD;   // Forward wins over back
                end else if (move_back) begin
                    pose_next = sprite_pkg::BACKWARD;
                end else begin
                    pose_next = sprite_pkg::IDLE;
                end
            end
        endcase
    end

    // Pose and position only move at frame start, so the sprite never tears
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pose     <= sprite_pkg::IDLE;
            sprite_x <= '0;
            sprite_y <= '0;
        end else if (frame_start) begin
            pose     <= pose_next;
            sprite_x <= pos_x;
            sprite_y <= pos_y;
        end
    end

endmodule

`default_nettype wire

/* verilog/sprite_rom_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module sprite_rom_bank (
    input  wire logic                  clk,
    input  wire sprite_pkg::pose_t     pose,
    input  wire sprite_pkg::rom_addr_t rom_addr,
    output sprite_pkg::color_t         texel
);

    localparam int DEPTH = sprite_pkg::FRAME_COUNT * sprite_pkg::FRAME_WORDS;

    sprite_pkg::color_t mem [0:DEPTH-1];
    logic [10:0]        index;

    // Stand-in artwork: key on a diagonal stripe, frame number in the top bits
    function automatic sprite_pkg::color_t texel_rule(
        input logic [2:0] f,
        input logic [3:0] r,
        input logic [3:0] c
    );
        logic [3:0] diag;
        logic [5:0] shade;
        diag  = r + c;
        shade = {1'b0, r, 1'b0} + {2'b00, c};
        if (diag[1:0] == 2'd3) begin
            texel_rule = sprite_pkg::TRANSPARENT_COLOR;
        end else begin
            texel_rule = {f, shade[4:0]};
        end
    endfunction

    initial begin
        for (int f = 0; f < sprite_pkg::FRAME_COUNT; f++) begin
            for (int a = 0; a < sprite_pkg::FRAME_WORDS; a++) begin
                mem[f * sprite_pkg::FRAME_WORDS + a] =
                    texel_rule(3'(f), 4'(a / 16), 4'(a % 16));  // Row major
            end
        end
    end

    assign index = {pose, rom_addr};  // Frame select on top of the texel index

    always_ff @(posedge clk) begin
        texel <= mem[index];
    end

endmodule

`default_nettype wire

/* verilog/sprite_compositor.sv */
`timescale 1ns/1ns
`default_nettype none

module sprite_compositor (
    input  wire logic                clk,
    input  wire logic                rst,
    raster_if.view                   raster,
    input  wire sprite_pkg::coord_t  sprite_x,
    input  wire sprite_pkg::coord_t  sprite_y,
    input  wire sprite_pkg::color_t  texel,
    output sprite_pkg::rom_addr_t    rom_addr,
    output sprite_pkg::color_t       color,
    output logic                     sprite_hit,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     frame_out,
    output sprite_pkg::coord_t       pixel_x,
    output sprite_pkg::coord_t       pixel_y
);

    logic [10:0]        x_end;     // One past the right edge, no wrap
    logic [10:0]        y_end;
    logic               in_box;
    sprite_pkg::coord_t col;
    sprite_pkg::coord_t row;

    // Stage 1 registers
    logic               in_box_q;
    logic               hsync_q;
    logic               vsync_q;
    logic               origin_q;
    sprite_pkg::coord_t x_q;
    sprite_pkg::coord_t y_q;

    assign x_end = {1'b0, sprite_x} + {1'b0, sprite_pkg::SPRITE_W};
    assign y_end = {1'b0, sprite_y} + {1'b0, sprite_pkg::SPRITE_H};

    assign in_box = raster.active &&
                    (raster.x >= sprite_x) && ({1'b0, raster.x} < x_end) &&
                    (raster.y >= sprite_y) && ({1'b0, raster.y} < y_end);

    assign col = raster.x - sprite_x;
    assign row = raster.y - sprite_y;

    // The ROM read register is the stage 1 register of the texel path
    assign rom_addr = {row[3:0], col[3:0]};  // row * 16 + col

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_box_q <= 1'b0;
            hsync_q  <= 1'b0;
            vsync_q  <= 1'b0;
            origin_q <= 1'b0;
            x_q      <= '0;
            y_q      <= '0;
        end else begin
            in_box_q <= in_box;
            hsync_q  <= raster.hsync;
            vsync_q  <= raster.vsync;
            origin_q <= (raster.x == '0) && (raster.y == '0);
            x_q      <= raster.x;
            y_q      <= raster.y;
        end
    end

    // Stage 2, texel arrives from the ROM this cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            color      <= sprite_pkg::BACKGROUND_COLOR;
            sprite_hit <= 1'b0;
            hsync      <= 1'b0;
            vsync      <= 1'b0;
            frame_out  <= 1'b0;
            pixel_x    <= '0;
            pixel_y    <= '0;
        end else begin
            if (in_box_q && (texel != sprite_pkg::TRANSPARENT_COLOR)) begin
                color      <= texel;
                sprite_hit <= 1'b1;
            end else begin
                color      <= sprite_pkg::BACKGROUND_COLOR;  // Outside or keyed out
                sprite_hit <= 1'b0;
            end
            hsync     <= hsync_q;
            vsync     <= vsync_q;
            frame_out <= origin_q;
            pixel_x   <= x_q;
            pixel_y   <= y_q;
        end
    end

endmodule

`default_nettype wire

/* verilog/sprite_renderer_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sprite_renderer_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                move_fwd,
    input  wire logic                move_back,
    input  wire logic                attack,
    input  wire sprite_pkg::coord_t  pos_x,
    input  wire sprite_pkg::coord_t  pos_y,
    output sprite_pkg::color_t       color,
    output logic                     sprite_hit,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     frame_out,
    output sprite_pkg::coord_t       pixel_x,
    output sprite_pkg::coord_t       pixel_y
);

    logic                  frame_start;
    sprite_pkg::pose_t     pose;
    sprite_pkg::coord_t    sprite_x;
    sprite_pkg::coord_t    sprite_y;
    sprite_pkg::rom_addr_t rom_addr;
    sprite_pkg::color_t    texel;

    raster_if raster_bus ();  // Scan position, scanner to compositor

    raster_scan raster_scan_inst (
        .clk         (clk),
        .rst         (rst),
        .raster      (raster_bus.scan),
        .frame_start (frame_start)
    );

    player_pose player_pose_inst (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .move_fwd    (move_fwd),
        .move_back   (move_back),
        .attack      (attack),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .pose        (pose),
        .sprite_x    (sprite_x),
        .sprite_y    (sprite_y)
    );

    sprite_rom_bank sprite_rom_bank_inst (
        .clk      (clk),
        .pose     (pose),
        .rom_addr (rom_addr),
        .texel    (texel)
    );

    sprite_compositor sprite_compositor_inst (
        .clk        (clk),
        .rst        (rst),
        .raster     (raster_bus.view),
        .sprite_x   (sprite_x),
        .sprite_y   (sprite_y),
        .texel      (texel),
        .rom_addr   (rom_addr),
        .color      (color),
        .sprite_hit (sprite_hit),
        .hsync      (hsync),
        .vsync      (vsync),
        .frame_out  (frame_out),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y)
    );

endmodule

`default_nettype wire

/* bench/pixel_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_checker (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire sprite_pkg::color_t  color,
    input  wire logic                sprite_hit,
    input  wire logic                hsync,
    input  wire logic                vsync,
    input  wire logic                frame_out,
    input  wire sprite_pkg::coord_t  pixel_x,
    input  wire sprite_pkg::coord_t  pixel_y,
    input  wire logic                probe_valid,
    input  wire sprite_pkg::coord_t  probe_x [4],
    input  wire sprite_pkg::coord_t  probe_y [4],
    input  wire sprite_pkg::color_t  probe_color [4],
    input  wire logic                probe_hit [4],
    output int                       value_errors,
    output int                       sync_errors,
    output int                       frame_errors
);

    sprite_pkg::coord_t px [4];
    sprite_pkg::coord_t py [4];
    sprite_pkg::color_t pc [4];
    logic               ph [4];
    logic               armed [4];
    logic               seen [4];
    logic               started;       // First frame_out seen
    logic               hsync_exp;
    logic               vsync_exp;
    logic               frame_exp;

    initial begin
        value_errors = 0;
        sync_errors  = 0;
        frame_errors = 0;
        started      = 1'b0;
        for (int i = 0; i < 4; i++) begin
            armed[i] = 1'b0;
            seen[i]  = 1'b0;
        end
    end

    assign hsync_exp = (pixel_x >= 10'd68) && (pixel_x < 10'd76);
    assign vsync_exp = (pixel_y >= 10'd49) && (pixel_y < 10'd51);
    assign frame_exp = (pixel_x == '0) && (pixel_y == '0);

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            started = 1'b0;
            if (color !== 8'h00) begin
                $display("[FAIL] t=%0t color in reset: expected 00, got %h", $time, color);
                value_errors++;
            end
            if (sprite_hit !== 1'b0) begin
                $display("[FAIL] t=%0t sprite_hit in reset: expected 0, got %b",
                         $time, sprite_hit);
                value_errors++;
            end
            if (hsync !== 1'b0) begin
                $display("[FAIL] t=%0t hsync in reset: expected 0, got %b", $time, hsync);
                value_errors++;
            end
            if (vsync !== 1'b0) begin
                $display("[FAIL] t=%0t vsync in reset: expected 0, got %b", $time, vsync);
                value_errors++;
            end
        end else begin
            if (probe_valid) begin
                for (int i = 0; i < 4; i++) begin
                    if (armed[i] && !seen[i]) begin
                        $display("Probe %0d at (%0d,%0d) was never displayed, time %0t",
                                 i, px[i], py[i], $time);
                        value_errors++;
                    end
                    px[i]    = probe_x[i];
                    py[i]    = probe_y[i];
                    pc[i]    = probe_color[i];
                    ph[i]    = probe_hit[i];
                    armed[i] = 1'b1;
                    seen[i]  = 1'b0;
                end
            end

            if (hsync !== hsync_exp) begin
                $display("[FAIL] t=%0t hsync at (%0d,%0d): expected %b, got %b",
                         $time, pixel_x, pixel_y, hsync_exp, hsync);
                sync_errors++;
            end
            if (vsync !== vsync_exp) begin
                $display("[FAIL] t=%0t vsync at (%0d,%0d): expected %b, got %b",
                         $time, pixel_x, pixel_y, vsync_exp, vsync);
                sync_errors++;
            end

            if (frame_out) begin
                started = 1'b1;
            end
            // Origin and frame_out must coincide once the pipeline is full
            if (started && (frame_out !== frame_exp)) begin
                $display("[FAIL] t=%0t frame_out at (%0d,%0d): expected %b, got %b",
                         $time, pixel_x, pixel_y, frame_exp, frame_out);
                frame_errors++;
            end

            for (int i = 0; i < 4; i++) begin
                if (armed[i] && !seen[i] && pixel_x == px[i] && pixel_y == py[i]) begin
                    seen[i] = 1'b1;
                    if (color !== pc[i]) begin
                        $display("[FAIL] t=%0t color at (%0d,%0d): expected %h, got %h",
                                 $time, px[i], py[i], pc[i], color);
                        value_errors++;
                    end
                    if (sprite_hit !== ph[i]) begin
                        $display("[FAIL] t=%0t sprite_hit at (%0d,%0d): expected %b, got %b",
                                 $time, px[i], py[i], ph[i], sprite_hit);
                        value_errors++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/sprite_renderer_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module sprite_renderer_tb;

    localparam int WAIT_LIMIT = 2 * 80 * 52;  // Two whole frames

    logic               clk;
    logic               rst;
    logic               move_fwd;
    logic               move_back;
    logic               attack;
    sprite_pkg::coord_t pos_x;
    sprite_pkg::coord_t pos_y;
    sprite_pkg::color_t color;
    logic               sprite_hit;
    logic               hsync;
    logic               vsync;
    logic               frame_out;
    sprite_pkg::coord_t pixel_x;
    sprite_pkg::coord_t pixel_y;

    logic               probe_valid;
    sprite_pkg::coord_t probe_x [4];
    sprite_pkg::coord_t probe_y [4];
    sprite_pkg::color_t probe_color [4];
    logic               probe_hit [4];

    int value_errors;
    int sync_errors;
    int frame_errors;
    int other_errors;
    int fd;
    int f_ctl [5];                              // fwd, back, attack, pos_x, pos_y
    int f_x [4];
    int f_y [4];
    int f_c [4];
    int f_h [4];
    bit have_line;
    bit abort;
    bit got_pulse;

    sprite_renderer_top sprite_renderer_top_inst (
        .clk        (clk),
        .rst        (rst),
        .move_fwd   (move_fwd),
        .move_back  (move_back),
        .attack     (attack),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .color      (color),
        .sprite_hit (sprite_hit),
        .hsync      (hsync),
        .vsync      (vsync),
        .frame_out  (frame_out),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y)
    );

    pixel_checker pixel_checker_inst (
        .clk          (clk),
        .rst          (rst),
        .color        (color),
        .sprite_hit   (sprite_hit),
        .hsync        (hsync),
        .vsync        (vsync),
        .frame_out    (frame_out),
        .pixel_x      (pixel_x),
        .pixel_y      (pixel_y),
        .probe_valid  (probe_valid),
        .probe_x      (probe_x),
        .probe_y      (probe_y),
        .probe_color  (probe_color),
        .probe_hit    (probe_hit),
        .value_errors (value_errors),
        .sync_errors  (sync_errors),
        .frame_errors (frame_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Next frame line, comment and blank lines skipped
    task automatic read_frame_line(output bit got);
        string line;
        int    n;
        got = 1'b0;
        while (!got && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %h %d %d %d %h %d %d %d %h %d %d %d %h %d",
                            f_ctl[0], f_ctl[1], f_ctl[2], f_ctl[3], f_ctl[4],
                            f_x[0], f_y[0], f_c[0], f_h[0], f_x[1], f_y[1], f_c[1], f_h[1],
                            f_x[2], f_y[2], f_c[2], f_h[2], f_x[3], f_y[3], f_c[3], f_h[3]);
                if (n == 21) begin
                    got = 1'b1;
                end else begin
                    $display("Malformed line in the test data file: %s", line);
                    other_errors++;
                end
            end
        end
    endtask

    task automatic wait_frame_pulse(output bit ok);
        int count;
        ok    = 1'b0;
        count = 0;
        while (!ok && count < WAIT_LIMIT) begin
            @(negedge clk);
            ok = frame_out;
            count++;
        end
        if (!ok) begin
            $display("Timed out waiting for frame_out at %0t", $time);
            other_errors++;
        end
    endtask

    initial begin
        rst          = 1'b1;
        move_fwd     = 1'b0;
        move_back    = 1'b0;
        attack       = 1'b0;
        pos_x        = '0;
        pos_y        = '0;
        probe_valid  = 1'b0;
        other_errors = 0;
        abort        = 1'b0;
        for (int i = 0; i < 4; i++) begin
            probe_x[i]     = '0;
            probe_y[i]     = '0;
            probe_color[i] = '0;
            probe_hit[i]   = 1'b0;
        end

        fd = $fopen("bench/sprite_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            other_errors++;
            abort = 1'b1;
            have_line = 1'b0;
        end else begin
            read_frame_line(have_line);
        end

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        if (have_line) begin
            move_fwd  <= f_ctl[0][0];
            move_back <= f_ctl[1][0];
            attack    <= f_ctl[2][0];
            pos_x     <= 10'(f_ctl[3]);
            pos_y     <= 10'(f_ctl[4]);
        end

        // Controls of line N are sampled at frame N start, its probes show in output frame N
        while (have_line && !abort) begin
            wait_frame_pulse(got_pulse);
            if (!got_pulse) begin
                abort = 1'b1;
            end else begin
                @(posedge clk);
                for (int i = 0; i < 4; i++) begin
                    probe_x[i]     <= 10'(f_x[i]);
                    probe_y[i]     <= 10'(f_y[i]);
                    probe_color[i] <= 8'(f_c[i]);
                    probe_hit[i]   <= f_h[i][0];
                end
                probe_valid <= 1'b1;
                read_frame_line(have_line);
                if (have_line) begin
                    move_fwd  <= f_ctl[0][0];
                    move_back <= f_ctl[1][0];
                    attack    <= f_ctl[2][0];
                    pos_x     <= 10'(f_ctl[3]);
                    pos_y     <= 10'(f_ctl[4]);
                end
                @(posedge clk);
                probe_valid <= 1'b0;
            end
        end

        // Off-screen probes retire the last real set
        if (!abort) begin
            wait_frame_pulse(got_pulse);
            if (got_pulse) begin
                @(posedge clk);
                for (int i = 0; i < 4; i++) begin
                    probe_x[i] <= 10'd1023;
                    probe_y[i] <= 10'd1023;
                end
                probe_valid <= 1'b1;
                @(posedge clk);
                probe_valid <= 1'b0;
                @(posedge clk);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Errors: value %0d, sync %0d, frame %0d, other %0d",
                 value_errors, sync_errors, frame_errors, other_errors);
        if (value_errors + sync_errors + frame_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/sprite_testdata.txt */
# fwd back attack pos_x pos_y, then four probes of x y color(hex) hit
# line N controls take effect in video frame N, where its probes are checked
0 0 0 0 0   20 20 00 0   40 10 00 0   16 5 00 0   5 16 00 0
0 0 0 10 8   13 9 05 1   12 9 00 0   26 10 00 0   15 24 00 0
1 0 0 10 8   13 9 25 1   20 12 32 1   11 8 21 1   12 9 00 0
0 1 0 10 8   13 9 45 1   20 12 52 1   11 8 41 1   26 10 00 0
1 1 0 10 8   13 9 25 1   11 8 21 1   20 12 32 1   12 9 00 0
0 0 1 10 8   13 9 65 1   11 8 61 1   20 12 72 1   12 9 00 0
0 0 0 10 8   13 9 A5 1   11 8 A1 1   20 12 B2 1   12 9 00 0
0 0 0 10 8   13 9 85 1   11 8 81 1   20 12 92 1   26 10 00 0
0 0 0 40 30   41 30 01 1   43 31 05 1   13 9 00 0   11 8 00 0
0 1 0 30 20   31 20 41 1   33 21 45 1   41 30 5F 1   50 40 00 0
0 0 0 20 20   35 35 0D 1   34 35 0C 1   35 34 0B 1   36 35 00 0
1 0 1 20 20   21 20 61 1   35 35 6D 1   23 21 65 1   22 21 00 0
1 0 0 20 20   21 20 A1 1   35 35 AD 1   23 21 A5 1   22 21 00 0
0 0 1 20 20   21 20 81 1   35 35 8D 1   23 21 85 1   22 21 00 0
0 0 1 20 20   21 20 61 1   35 35 6D 1   23 21 65 1   22 21 00 0

/* build.f */
verilog/sprite_pkg.sv
verilog/raster_if.sv
verilog/raster_scan.sv
verilog/player_pose.sv
verilog/sprite_rom_bank.sv
verilog/sprite_compositor.sv
verilog/sprite_renderer_top.sv
bench/pixel_checker.sv
bench/sprite_renderer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module sprite_renderer_tb \
    -o sprite_sim > build.log 2>&1 \
    && ./obj_dir/sprite_sim > sim.log 2>&1 \
    || { echo "Build or run error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
